//--- filelist.f
verilog/div_pkg.sv
verilog/div_wb_regs.sv
verilog/div_ctrl_fsm.sv
verilog/div_step_counter.sv
verilog/div_operand_prep.sv
verilog/div_shift_subtract.sv
verilog/div_result_fix.sv
verilog/div_wb_top.sv
tb/div_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the divider testbench with verilator, run it and judge the output
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module div_tb -Mdir obj_dir -o div_sim -f filelist.f || exit 1
out=$(./obj_dir/div_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

//--- tb/div_tb.sv
module div_tb
	import div_pkg::*;
();

	logic      clk = 1'b0;
	logic      rst_n;
	logic      cyc;
	logic      stb;
	logic      we;
	bus_adr_t  adr;
	bus_data_t dat_w;
	bus_data_t dat_r;
	logic      ack;

	div_wb_top dut0 (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	always #10 clk = ~clk;

	task automatic abort_sim();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
			abort_sim();
		end
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(negedge clk);  // ack and dat_r are settled here
			n++;
		end while (!ack && n < 20);
		if (!ack) begin
			$display("the bus slave did not acknowledge the access at %0t", $time);
			abort_sim();
		end
	endtask

	task automatic bus_write(input bus_adr_t a, input bus_data_t d);
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= 1'b1;
		adr   <= a;
		dat_w <= d;
		wait_ack();
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic bus_read(input bus_adr_t a, output bus_data_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		wait_ack();
		d = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	function automatic xlen_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic bus_data_t ctrl_bits(input logic s, input logic w);
		bus_data_t c;
		c = '0;
		c[ctrl_signed_bit] = s;
		c[ctrl_word_bit]   = w;
		return c;
	endfunction

	// riscv div and rem rules where the word forms use sign or zero extended low halves
	task automatic model_div(input logic s, input logic w, input xlen_t a_in, input xlen_t b_in,
			output xlen_t q, output xlen_t r);
		xlen_t a;
		xlen_t b;
		a = a_in;
		b = b_in;
		if (w) begin
			a = s ? {{32{a_in[31]}}, a_in[31:0]} : {32'h0, a_in[31:0]};
			b = s ? {{32{b_in[31]}}, b_in[31:0]} : {32'h0, b_in[31:0]};
		end
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (s && a == 64'h8000_0000_0000_0000 && b == '1) begin
			q = a;  // overflow keeps the most negative value
			r = '0;
		end else if (s) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
		if (w) begin
			q = {{32{q[31]}}, q[31:0]};
			r = {{32{r[31]}}, r[31:0]};
		end
	endtask

	task automatic wait_done();
		bus_data_t st;
		int n;
		n = 0;
		st = '0;
		while (!st[status_done_bit] && n < 100) begin
			bus_read(reg_status, st);
			n++;
		end
		if (!st[status_done_bit]) begin
			$display("the divider never reported done at %0t", $time);
			abort_sim();
		end
	endtask

	task automatic load_operands(input xlen_t a, input xlen_t b);
		bus_write(reg_dvd_lo, a[31:0]);
		bus_write(reg_dvd_hi, a[63:32]);
		bus_write(reg_dvs_lo, b[31:0]);
		bus_write(reg_dvs_hi, b[63:32]);
	endtask

	task automatic check_results(input logic s, input logic w, input xlen_t a, input xlen_t b);
		xlen_t q_exp;
		xlen_t r_exp;
		bus_data_t lo;
		bus_data_t hi;
		model_div(s, w, a, b, q_exp, r_exp);
		bus_read(reg_quo_lo, lo);
		bus_read(reg_quo_hi, hi);
		check("quotient", {hi, lo}, q_exp);
		bus_read(reg_rem_lo, lo);
		bus_read(reg_rem_hi, hi);
		check("remainder", {hi, lo}, r_exp);
	endtask

	task automatic run_div(input logic s, input logic w, input xlen_t a, input xlen_t b);
		load_operands(a, b);
		bus_write(reg_ctrl, ctrl_bits(s, w));
		wait_done();
		check_results(s, w, a, b);
	endtask

	function automatic xlen_t corner(input logic w, input bus_data_t low, input xlen_t full);
		return w ? {$urandom, low} : full;  // upper half is noise in word mode
	endfunction

	initial begin
		logic s;
		logic w;
		xlen_t a;
		xlen_t b;
		bus_data_t v;
		bus_data_t rd;
		cyc   <= 1'b0;
		stb   <= 1'b0;
		we    <= 1'b0;
		adr   <= '0;
		dat_w <= '0;
		rst_n <= 1'b0;
		void'($urandom(32'ha6b7_85e7));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// register readback and the unmapped words
		for (int i = 0; i < 4; i++) begin
			v = $urandom;
			bus_write(bus_adr_t'(i), v);
			bus_read(bus_adr_t'(i), rd);
			check("operand register", 64'(rd), 64'(v));
		end
		v = ctrl_bits(1'($urandom), 1'($urandom));
		for (int k = 0; k < 2; k++) begin
			bus_write(reg_ctrl, v);
			bus_read(reg_ctrl, rd);
			check("ctrl", 64'(rd), 64'(v));
			wait_done();
			v = v ^ ctrl_bits(1'b1, 1'b1);  // the second pass sees each mode bit flipped
		end
		for (int i = 10; i < 16; i++) begin
			bus_write(bus_adr_t'(i), $urandom);
			bus_read(bus_adr_t'(i), rd);
			check("unmapped register", 64'(rd), 64'h0);
		end

		repeat (300) begin
			s = 1'($urandom);
			b = rand64() >> ($urandom % 64);
			run_div(s, 1'b0, rand64(), 1'($urandom) ? -b : b);
		end

		repeat (200) begin
			s = 1'($urandom);
			b = {$urandom, $urandom >> ($urandom % 32)};
			run_div(s, 1'b1, rand64(), 1'($urandom) ? -b : b);
		end

		for (int m = 0; m < 4; m++) begin
			s = m[0];
			w = m[1];
			run_div(s, w, rand64(), corner(w, 32'h0, 64'h0));
			run_div(s, w, corner(w, 32'h8000_0000, 64'h8000_0000_0000_0000),
				corner(w, 32'hffff_ffff, '1));
			run_div(s, w, corner(w, 32'h0, 64'h0), rand64());
			run_div(s, w, rand64(), corner(w, 32'h1, 64'h1));
		end

		// a control write during a run must not restart it
		a = rand64();
		b = rand64() >> 20;
		load_operands(a, b);
		bus_write(reg_ctrl, ctrl_bits(1'b1, 1'b0));
		bus_read(reg_status, rd);
		check("status busy", 64'(rd[status_busy_bit]), 64'h1);
		check("status done", 64'(rd[status_done_bit]), 64'h0);
		bus_write(reg_ctrl, ctrl_bits(1'b0, 1'b1));
		bus_read(reg_ctrl, rd);
		check("ctrl while busy", 64'(rd), 64'(ctrl_bits(1'b1, 1'b0)));
		wait_done();
		check_results(1'b1, 1'b0, a, b);
		repeat (3) begin
			bus_read(reg_status, rd);
			check("sticky status", 64'(rd), 64'(1 << status_done_bit));
		end
		bus_write(reg_ctrl, ctrl_bits(1'b0, 1'b1));
		bus_read(reg_status, rd);
		check("status after restart", 64'(rd), 64'(1 << status_busy_bit));
		wait_done();
		check_results(1'b0, 1'b1, a, b);

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- verilog/div_wb_top.sv
module div_wb_top
	import div_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cyc,
	input  logic      stb,
	input  logic      we,
	input  bus_adr_t  adr,
	input  bus_data_t dat_w,
	output bus_data_t dat_r,
	output logic      ack
);

	logic  start;
	logic  signed_op;
	logic  word_op;
	xlen_t dividend;
	xlen_t divisor;
	logic  load;
	logic  step;
	logic  busy;
	logic  finish;
	logic  last;
	xlen_t dividend_mag;
	xlen_t divisor_mag;
	logic  neg_quo;
	logic  neg_rem;
	logic  word_mode;
	xlen_t quo_raw;
	xlen_t rem_raw;
	xlen_t quotient;
	xlen_t remainder;

	div_wb_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.busy      (busy),
		.finish    (finish),
		.quotient  (quotient),
		.remainder (remainder),
		.dat_r     (dat_r),
		.ack       (ack),
		.start     (start),
		.signed_op (signed_op),
		.word_op   (word_op),
		.dividend  (dividend),
		.divisor   (divisor)
	);

	div_ctrl_fsm u_fsm (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.last   (last),
		.load   (load),
		.step   (step),
		.busy   (busy),
		.finish (finish)
	);

	div_step_counter u_cnt (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load),
		.step      (step),
		.word_mode (word_mode),  // registered copy, stable while stepping
		.last      (last)
	);

	div_operand_prep u_prep (
		.clk          (clk),
		.rst_n        (rst_n),
		.load         (load),
		.signed_op    (signed_op),
		.word_op      (word_op),
		.dividend     (dividend),
		.divisor      (divisor),
		.dividend_mag (dividend_mag),
		.divisor_mag  (divisor_mag),
		.neg_quo      (neg_quo),
		.neg_rem      (neg_rem),
		.word_mode    (word_mode)
	);

	div_shift_subtract u_dp (
		.clk          (clk),
		.rst_n        (rst_n),
		.load         (load),
		.step         (step),
		.dividend_mag (dividend_mag),
		.divisor_mag  (divisor_mag),
		.quo_raw      (quo_raw),
		.rem_raw      (rem_raw)
	);

	div_result_fix u_fix (
		.quo_raw   (quo_raw),
		.rem_raw   (rem_raw),
		.neg_quo   (neg_quo),
		.neg_rem   (neg_rem),
		.word_mode (word_mode),
		.quotient  (quotient),
		.remainder (remainder)
	);

endmodule

//--- verilog/div_result_fix.sv
module div_result_fix
	import div_pkg::*;
(
	input  xlen_t quo_raw,
	input  xlen_t rem_raw,
	input  logic  neg_quo,
	input  logic  neg_rem,
	input  logic  word_mode,
	output xlen_t quotient,
	output xlen_t remainder
);

	xlen_t quo_s;
	xlen_t rem_s;

	assign quo_s = neg_quo ? -quo_raw : quo_raw;
	assign rem_s = neg_rem ? -rem_raw : rem_raw;  // remainder takes the dividend sign

	// word forms always sign-extend, the unsigned ones included
	assign quotient = word_mode ? {{(xlen-bus_width){quo_s[bus_width-1]}}, quo_s[bus_width-1:0]}
	                            : quo_s;
	assign remainder = word_mode ? {{(xlen-bus_width){rem_s[bus_width-1]}}, rem_s[bus_width-1:0]}
	                             : rem_s;

endmodule

//--- verilog/div_shift_subtract.sv
module div_shift_subtract
	import div_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load,
	input  logic  step,
	input  xlen_t dividend_mag,
	input  xlen_t divisor_mag,
	output xlen_t quo_raw,
	output xlen_t rem_raw
);

	logic [2*xlen-1:0] rem_sr;  // partial remainder above, unconsumed dividend below
	xlen_t             dvs_q;
	xlen_t             quo_q;
	logic [xlen:0]     trial;

	// the upper half shifted left by one, minus the divisor
	assign trial = rem_sr[2*xlen-1:xlen-1] - {1'b0, dvs_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem_sr <= '0;
			dvs_q  <= '0;
			quo_q  <= '0;
		end else if (load) begin
			rem_sr <= {{xlen{1'b0}}, dividend_mag};
			dvs_q  <= divisor_mag;
			quo_q  <= '0;
		end else if (step) begin
			if (trial[xlen]) begin
				// borrow, so the divisor does not fit and only the shift happens
				rem_sr <= {rem_sr[2*xlen-2:0], 1'b0};
				quo_q  <= {quo_q[xlen-2:0], 1'b0};
			end else begin
				rem_sr <= {trial[xlen-1:0], rem_sr[xlen-2:0], 1'b0};
				quo_q  <= {quo_q[xlen-2:0], 1'b1};
			end
		end
	end

	assign quo_raw = quo_q;
	assign rem_raw = rem_sr[2*xlen-1:xlen];  // remainder sits in the upper half

endmodule

//--- verilog/div_operand_prep.sv
module div_operand_prep
	import div_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  load,
	input  logic  signed_op,
	input  logic  word_op,
	input  xlen_t dividend,
	input  xlen_t divisor,
	output xlen_t dividend_mag,
	output xlen_t divisor_mag,
	output logic  neg_quo,
	output logic  neg_rem,
	output logic  word_mode
);

	logic  dvd_neg;
	logic  dvs_neg;
	logic  dvs_zero;
	xlen_t dvd_abs;
	xlen_t dvs_abs;

	assign dvd_neg  = signed_op && (word_op ? dividend[bus_width-1] : dividend[xlen-1]);
	assign dvs_neg  = signed_op && (word_op ? divisor[bus_width-1] : divisor[xlen-1]);
	assign dvs_zero = word_op ? (divisor[bus_width-1:0] == '0) : (divisor == '0);

	// the low word of a negation only depends on the low word, so word mode can reuse it
	assign dvd_abs = dvd_neg ? -dividend : dividend;
	assign dvs_abs = dvs_neg ? -divisor : divisor;

	// word dividend goes to the top so that 32 steps consume all of it
	assign dividend_mag = word_op ? {dvd_abs[bus_width-1:0], {bus_width{1'b0}}} : dvd_abs;
	assign divisor_mag  = word_op ? {{bus_width{1'b0}}, dvs_abs[bus_width-1:0]} : dvs_abs;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			neg_quo   <= 1'b0;
			neg_rem   <= 1'b0;
			word_mode <= 1'b0;
		end else if (load) begin
			neg_quo   <= (dvd_neg ^ dvs_neg) && !dvs_zero;  // keeps all ones on divide by zero
			neg_rem   <= dvd_neg;
			word_mode <= word_op;
		end
	end

endmodule

//--- verilog/div_step_counter.sv
module div_step_counter
	import div_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic step,
	input  logic word_mode,
	output logic last
);

	step_cnt_t count;
	step_cnt_t final_cnt;

	assign final_cnt = (word_mode ? steps_word : steps_double) - step_cnt_t'(1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= '0;
		end else if (step) begin
			count <= count + step_cnt_t'(1);  // stops at the full length after last
		end
	end

	assign last = step && (count == final_cnt);

endmodule

//--- verilog/div_ctrl_fsm.sv
module div_ctrl_fsm
	import div_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic last,
	output logic load,
	output logic step,
	output logic busy,
	output logic finish
);

	div_state_t state;
	div_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (load) begin  // operands are captured in this cycle
					state_nxt = st_run;
				end
			end
			st_run: begin
				if (last) begin
					state_nxt = st_done;
				end
			end
			st_done: state_nxt = st_idle;  // results are latched at this edge
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			load  <= 1'b0;
		end else begin
			state <= state_nxt;
			load  <= start;  // one cycle behind the control write
		end
	end

	assign step   = (state == st_run);
	assign busy   = load || (state != st_idle);  // covers the load cycle as well
	assign finish = (state == st_done);

endmodule

//--- verilog/div_wb_regs.sv
module div_wb_regs
	import div_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cyc,
	input  logic      stb,
	input  logic      we,
	input  bus_adr_t  adr,
	input  bus_data_t dat_w,
	input  logic      busy,
	input  logic      finish,
	input  xlen_t     quotient,
	input  xlen_t     remainder,
	output bus_data_t dat_r,
	output logic      ack,
	output logic      start,
	output logic      signed_op,
	output logic      word_op,
	output xlen_t     dividend,
	output xlen_t     divisor
);

	logic      req;
	logic      wr_en;
	logic      done;
	xlen_t     quo_q;
	xlen_t     rem_q;
	bus_data_t rd_data;

	assign req   = cyc && stb && !ack;  // new access, the ack cycle itself is skipped
	assign wr_en = req && we;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dividend  <= '0;
			divisor   <= '0;
			signed_op <= 1'b0;
			word_op   <= 1'b0;
			start     <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_en) begin
				case (adr)
					reg_dvd_lo: dividend[bus_width-1:0]    <= dat_w;
					reg_dvd_hi: dividend[xlen-1:bus_width] <= dat_w;
					reg_dvs_lo: divisor[bus_width-1:0]     <= dat_w;
					reg_dvs_hi: divisor[xlen-1:bus_width]  <= dat_w;
					reg_ctrl: begin
						if (!busy) begin  // a running division is left alone
							signed_op <= dat_w[ctrl_signed_bit];
							word_op   <= dat_w[ctrl_word_bit];
							start     <= 1'b1;
						end
					end
					default: ;  // status and results are read-only
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			quo_q <= '0;
			rem_q <= '0;
			done  <= 1'b0;
		end else if (finish) begin
			quo_q <= quotient;
			rem_q <= remainder;
			done  <= 1'b1;
		end else if (start) begin
			done <= 1'b0;
		end
	end

	always_comb begin
		rd_data = '0;
		case (adr)
			reg_dvd_lo: rd_data = dividend[bus_width-1:0];
			reg_dvd_hi: rd_data = dividend[xlen-1:bus_width];
			reg_dvs_lo: rd_data = divisor[bus_width-1:0];
			reg_dvs_hi: rd_data = divisor[xlen-1:bus_width];
			reg_ctrl: begin
				rd_data[ctrl_signed_bit] = signed_op;
				rd_data[ctrl_word_bit]   = word_op;
			end
			reg_status: begin
				rd_data[status_busy_bit] = busy;
				rd_data[status_done_bit] = done;
			end
			reg_quo_lo: rd_data = quo_q[bus_width-1:0];
			reg_quo_hi: rd_data = quo_q[xlen-1:bus_width];
			reg_rem_lo: rd_data = rem_q[bus_width-1:0];
			reg_rem_hi: rd_data = rem_q[xlen-1:bus_width];
			default: rd_data = '0;  // unmapped words read as zero
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dat_r <= '0;
		end else if (req && !we) begin
			dat_r <= rd_data;  // valid together with ack
		end
	end

endmodule

//--- verilog/div_pkg.sv
package div_pkg;

	localparam int xlen       = 64;
	localparam int bus_width  = 32;
	localparam int adr_width  = 4;
	localparam int step_width = 7;

	typedef logic [xlen-1:0]       xlen_t;      // operand or result word
	typedef logic [bus_width-1:0]  bus_data_t;  // wishbone data word
	typedef logic [adr_width-1:0]  bus_adr_t;   // word address, bus bits 5:2
	typedef logic [step_width-1:0] step_cnt_t;  // holds up to 64 steps

	// register map, one 32-bit word per address
	localparam bus_adr_t reg_dvd_lo = 4'd0;
	localparam bus_adr_t reg_dvd_hi = 4'd1;
	localparam bus_adr_t reg_dvs_lo = 4'd2;
	localparam bus_adr_t reg_dvs_hi = 4'd3;
	localparam bus_adr_t reg_ctrl   = 4'd4;
	localparam bus_adr_t reg_status = 4'd5;
	localparam bus_adr_t reg_quo_lo = 4'd6;
	localparam bus_adr_t reg_quo_hi = 4'd7;
	localparam bus_adr_t reg_rem_lo = 4'd8;
	localparam bus_adr_t reg_rem_hi = 4'd9;

	localparam int ctrl_signed_bit = 0;  // signed division
	localparam int ctrl_word_bit   = 1;  // 32-bit word form
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;  // sticky until next start

	localparam step_cnt_t steps_double = 7'd64;
	localparam step_cnt_t steps_word   = 7'd32;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} div_state_t;

endpackage
